// ==== test/ship_display_tests.txt ====
# cmd: W addr data | R addr expected | F | P x y rgb | S hsync_n vsync_n x y
# addr, x, y and syncs in decimal; data, expected and rgb in hex
# Reset values
R 0 0000
R 1 0000
R 2 0fff
R 3 0000
# Writes keep only the implemented bits
W 0 ffff
R 0 03ff
W 1 1234
R 1 0234
W 2 abcd
R 2 0bcd
W 3 f123
R 3 0123
# Red ship on dark blue at (100, 50)
W 2 0f00
W 3 0008
W 0 0064
W 1 0032
F
P 100 50 0008
P 124 56 0f00
P 124 65 0008
P 131 82 0f00
P 300 300 0008
S 0 1 700 100
S 1 1 760 100
P 700 100 000
S 1 0 100 490
# Move to (400, 300) in the middle of a frame
F
W 0 0190
W 1 012c
P 124 56 0f00
P 131 82 0f00
F
P 124 56 0008
P 424 306 0f00
P 431 332 0f00
# Ship at (600, 445) runs past the right and bottom edges
W 0 0258
W 1 01bd
F
P 635 475 0f00
P 640 475 000
P 612 481 000

// ==== files.f ====
+incdir+hw
hw/ship_pkg.sv
hw/scan_if.sv
hw/vga_timing.sv
hw/ship_rom.sv
hw/ship_regs.sv
hw/ship_renderer.sv
hw/ship_display_top.sv
test/tb_ship_display.sv

// ==== Bender.yml ====
package:
  name: ship_display

sources:
  - include_dirs:
      - hw
    files:
      - hw/ship_pkg.sv
      - hw/scan_if.sv
      - hw/vga_timing.sv
      - hw/ship_rom.sv
      - hw/ship_regs.sv
      - hw/ship_renderer.sv
      - hw/ship_display_top.sv

  - target: test
    files:
      - test/tb_ship_display.sv

// ==== test/tb_ship_display.sv ====
`timescale 1ns/1ps

module tb_ship_display
    import ship_pkg::*;
();

    localparam int LINE_CYCLES  = 800;
    localparam int FRAME_CYCLES = 420000;
    localparam int LATENCY      = 2;
    localparam int MAX_WAIT     = 500000;

    logic      clk;
    logic      arst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    wb_data_t  wb_dat_w;
    wb_data_t  wb_dat_r;
    logic      wb_ack;
    rgb_t      rgb;
    logic      hsync_n;
    logic      vsync_n;

    // Cycle index counted from reset release
    int cycle_cnt = 0;
    int pass_cnt  = 0;
    int fail_cnt  = 0;
    int test_num  = 0;
    bit aborted   = 1'b0;

    ship_display_top u_ship_display_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rgb      (rgb),
        .hsync_n  (hsync_n),
        .vsync_n  (vsync_n)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Drive and sample point just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic record(input bit ok, input string what);
        test_num++;
        if (ok) begin
            pass_cnt++;
            $display("test %0d %s ok", test_num, what);
        end else begin
            fail_cnt++;
            $display("test %0d %s error", test_num, what);
        end
    endtask

    // Command line must carry all of its fields
    function automatic bit fields_ok(input int got, input int want, input string what);
        if (got != want) begin
            $display("Malformed %s command in the test file", what);
        end
        return (got == want);
    endfunction

    // Classic cycle that expects ack exactly one cycle after the request
    task automatic bus_access(input bit we, input int adr, input int data,
                              output wb_data_t rdata, output bit ok);
        int waited;
        ok       = 1'b1;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = reg_addr_t'(adr);
        wb_dat_w = wb_data_t'(data);
        next_cycle();
        waited = 1;
        while (!wb_ack && waited < MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("Timeout: no Wishbone ack within %0d cycles", MAX_WAIT);
            aborted = 1'b1;
            ok      = 1'b0;
        end else if (waited != 1) begin
            $display("MISMATCH at %0t: ack after %0d cycles, expected 1", $time, waited);
            ok = 1'b0;
        end
        next_cycle();
        if (ok && wb_ack) begin
            $display("MISMATCH at %0t: ack held longer than one cycle", $time);
            ok = 1'b0;
        end
    endtask

    // First cycle at or after now whose index is phase modulo the frame
    function automatic int next_phase(input int phase);
        int target;
        target = cycle_cnt - (cycle_cnt % FRAME_CYCLES) + phase;
        if (target < cycle_cnt) begin
            target += FRAME_CYCLES;
        end
        return target;
    endfunction

    // Outputs for pixel (x, y) are valid LATENCY cycles after the counters
    function automatic int pixel_out_cycle(input int x, input int y);
        return next_phase((y * LINE_CYCLES + x + LATENCY) % FRAME_CYCLES);
    endfunction

    task automatic wait_for_cycle(input int target, output bit ok);
        int waited;
        waited = 0;
        while (cycle_cnt != target && waited < MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        ok = (cycle_cnt == target);
        if (!ok) begin
            $display("Timeout: cycle %0d not reached within %0d cycles", target, MAX_WAIT);
            aborted = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command interpreter
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int               fd;
        int               code;
        int               arg0;
        int               arg1;
        int               arg2;
        int               arg3;
        int               target;
        bit               ok;
        wb_data_t         rdata;
        logic [8*16-1:0]  cmd;
        logic [8*128-1:0] line_buf;

        clk      = 1'b0;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        fd = $fopen("test/ship_display_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/ship_display_tests.txt");
            aborted = 1'b1;
        end

        while (!aborted && $fscanf(fd, " %s", cmd) == 1) begin
            case (cmd)
                "#": begin
                    code = $fgets(line_buf, fd);
                end
                "W": begin
                    code = $fscanf(fd, " %d %h", arg0, arg1);
                    if (!fields_ok(code, 2, "W")) begin
                        aborted = 1'b1;
                    end else begin
                        bus_access(1'b1, arg0, arg1, rdata, ok);
                        record(ok, $sformatf("W %0d %h", arg0, arg1[15:0]));
                    end
                end
                "R": begin
                    code = $fscanf(fd, " %d %h", arg0, arg1);
                    if (!fields_ok(code, 2, "R")) begin
                        aborted = 1'b1;
                    end else begin
                        bus_access(1'b0, arg0, 0, rdata, ok);
                        if (ok && rdata !== wb_data_t'(arg1)) begin
                            $display("MISMATCH at %0t: register %0d reads %h, expected %h",
                                     $time, arg0, rdata, arg1[15:0]);
                            ok = 1'b0;
                        end
                        record(ok, $sformatf("R %0d", arg0));
                    end
                end
                "F": begin
                    // Shadows load at the edge that ends cycle 0 of a frame
                    target = next_phase(1);
                    if (target == cycle_cnt) begin
                        target += FRAME_CYCLES;
                    end
                    wait_for_cycle(target, ok);
                    record(ok, "F");
                end
                "P": begin
                    code = $fscanf(fd, " %d %d %h", arg0, arg1, arg2);
                    if (!fields_ok(code, 3, "P")) begin
                        aborted = 1'b1;
                    end else begin
                        wait_for_cycle(pixel_out_cycle(arg0, arg1), ok);
                        if (ok && rgb !== rgb_t'(arg2)) begin
                            $display("MISMATCH at %0t: pixel (%0d, %0d) is %h, expected %h",
                                     $time, arg0, arg1, rgb, rgb_t'(arg2));
                            ok = 1'b0;
                        end
                        record(ok, $sformatf("P %0d %0d", arg0, arg1));
                    end
                end
                "S": begin
                    code = $fscanf(fd, " %d %d %d %d", arg0, arg1, arg2, arg3);
                    if (!fields_ok(code, 4, "S")) begin
                        aborted = 1'b1;
                    end else begin
                        wait_for_cycle(pixel_out_cycle(arg2, arg3), ok);
                        if (ok && (hsync_n !== arg0[0] || vsync_n !== arg1[0])) begin
                            $display("MISMATCH at %0t: syncs at (%0d, %0d) are %b %b, expected %b %b",
                                     $time, arg2, arg3, hsync_n, vsync_n, arg0[0], arg1[0]);
                            ok = 1'b0;
                        end
                        record(ok, $sformatf("S %0d %0d", arg2, arg3));
                    end
                end
                default: begin
                    $display("Unknown command %0s in the test file", cmd);
                    aborted = 1'b1;
                end
            endcase
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Tests done: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !aborted) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/ship_display_top.sv ====
`timescale 1ns/1ps

module ship_display_top
    import ship_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  reg_addr_t wb_adr,
    input  wb_data_t  wb_dat_w,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack,
    output rgb_t      rgb,
    output logic      hsync_n,
    output logic      vsync_n
);

    scan_if scan ();

    // Shadowed position and live colours
    coord_t ship_x;
    coord_t ship_y;
    rgb_t   ship_color;
    rgb_t   bg_color;

    vga_timing u_vga_timing (
        .clk    (clk),
        .arst_n (arst_n),
        .scan   (scan.source)
    );

    ship_regs u_ship_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .scan       (scan.sink),
        .ship_x     (ship_x),
        .ship_y     (ship_y),
        .ship_color (ship_color),
        .bg_color   (bg_color)
    );

    ship_renderer u_ship_renderer (
        .clk        (clk),
        .arst_n     (arst_n),
        .scan       (scan.sink),
        .ship_x     (ship_x),
        .ship_y     (ship_y),
        .ship_color (ship_color),
        .bg_color   (bg_color),
        .rgb        (rgb),
        .hsync_n    (hsync_n),
        .vsync_n    (vsync_n)
    );

endmodule

// ==== hw/ship_renderer.sv ====
`timescale 1ns/1ps
`include "ship_defs.svh"

module ship_renderer
    import ship_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    scan_if.sink   scan,
    input  coord_t ship_x,
    input  coord_t ship_y,
    input  rgb_t   ship_color,
    input  rgb_t   bg_color,
    output rgb_t   rgb,
    output logic   hsync_n,
    output logic   vsync_n
);

    coord_t       dx;
    coord_t       dy;
    logic         in_box;
    sprite_addr_t rom_addr;
    sprite_row_t  rom_data;
    sprite_row_t  row_shifted;
    logic         pix_bit;

    logic         s1_hit;
    logic         s1_bit;
    logic         s1_visible;
    logic         s1_hsync_n;
    logic         s1_vsync_n;

    // Offsets wrap, so positions left of or above the ship fall out of range
    assign dx       = scan.x - ship_x;
    assign dy       = scan.y - ship_y;
    assign in_box   = (dx < coord_t'(`SHIP_W)) && (dy < coord_t'(`SHIP_H));
    assign rom_addr = sprite_addr_t'(dy);

    ship_rom u_ship_rom (
        .addr (rom_addr),
        .data (rom_data)
    );

    // Column dx lands on the top bit
    always_comb begin
        row_shifted = rom_data << dx;
        pix_bit     = row_shifted[`SHIP_W-1];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, hit test and bitmap lookup
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_hit     <= 1'b0;
            s1_bit     <= 1'b0;
            s1_visible <= 1'b0;
            s1_hsync_n <= 1'b1;
            s1_vsync_n <= 1'b1;
        end else begin
            s1_hit     <= in_box;
            s1_bit     <= pix_bit;
            s1_visible <= scan.visible;
            s1_hsync_n <= scan.hsync_n;
            s1_vsync_n <= scan.vsync_n;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, colour select
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb     <= '0;
            hsync_n <= 1'b1;
            vsync_n <= 1'b1;
        end else begin
            if (!s1_visible) begin
                rgb <= '0;
            end else if (s1_hit && s1_bit) begin
                rgb <= ship_color;
            end else begin
                rgb <= bg_color;
            end
            hsync_n <= s1_hsync_n;
            vsync_n <= s1_vsync_n;
        end
    end

endmodule

// ==== hw/ship_regs.sv ====
`timescale 1ns/1ps
`include "ship_defs.svh"

module ship_regs
    import ship_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  reg_addr_t wb_adr,
    input  wb_data_t  wb_dat_w,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack,
    scan_if.sink      scan,
    output coord_t    ship_x,
    output coord_t    ship_y,
    output rgb_t      ship_color,
    output rgb_t      bg_color
);

    coord_t x_reg;
    coord_t y_reg;
    logic   wb_req;
    logic   wr_en;

    // New request only while ack is low, so ack is a single cycle
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_en  = wb_req && wb_we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Programmed registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_reg      <= '0;
            y_reg      <= '0;
            ship_color <= 12'hFFF;
            bg_color   <= 12'h000;
        end else if (wr_en) begin
            case (wb_adr)
                reg_addr_t'(`REG_SHIP_X):     x_reg      <= coord_t'(wb_dat_w);
                reg_addr_t'(`REG_SHIP_Y):     y_reg      <= coord_t'(wb_dat_w);
                reg_addr_t'(`REG_SHIP_COLOR): ship_color <= rgb_t'(wb_dat_w);
                default:                      bg_color   <= rgb_t'(wb_dat_w);
            endcase
        end
    end

    // Position only moves between frames
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ship_x <= '0;
            ship_y <= '0;
        end else if (scan.frame_start) begin
            ship_x <= x_reg;
            ship_y <= y_reg;
        end
    end

    // Readback of programmed values, master holds adr through ack
    always_comb begin
        case (wb_adr)
            reg_addr_t'(`REG_SHIP_X):     wb_dat_r = wb_data_t'(x_reg);
            reg_addr_t'(`REG_SHIP_Y):     wb_dat_r = wb_data_t'(y_reg);
            reg_addr_t'(`REG_SHIP_COLOR): wb_dat_r = wb_data_t'(ship_color);
            default:                      wb_dat_r = wb_data_t'(bg_color);
        endcase
    end

endmodule

// ==== hw/ship_rom.sv ====
`timescale 1ns/1ps

module ship_rom
    import ship_pkg::*;
(
    input  sprite_addr_t addr,
    output sprite_row_t  data
);

    // Row patterns with column 0 in bit 49
    localparam sprite_row_t ROW_BLANK = 50'h0000000000000;
    // Gun barrel over columns 24-25
    localparam sprite_row_t ROW_GUN   = 50'h0000003000000;
    // Columns 23-26
    localparam sprite_row_t ROW_TOWER = 50'h0000007800000;
    // Columns 11-38
    localparam sprite_row_t ROW_DECK  = 50'h0007FFFFFF800;
    // Wide hull over columns 7-42
    localparam sprite_row_t ROW_HULL  = 50'h007FFFFFFFF80;

    always_comb begin
        case (addr)
            6'd0:    data = ROW_BLANK;
            6'd1:    data = ROW_BLANK;
            6'd2:    data = ROW_BLANK;
            6'd3:    data = ROW_BLANK;
            6'd4:    data = ROW_BLANK;
            6'd5:    data = ROW_BLANK;
            6'd6:    data = ROW_GUN;
            6'd7:    data = ROW_GUN;
            6'd8:    data = ROW_GUN;
            6'd9:    data = ROW_GUN;
            6'd10:   data = ROW_GUN;
            6'd11:   data = ROW_GUN;
            6'd12:   data = ROW_GUN;
            6'd13:   data = ROW_GUN;
            // Gap in the barrel
            6'd14:   data = ROW_BLANK;
            6'd15:   data = ROW_BLANK;
            6'd16:   data = ROW_GUN;
            6'd17:   data = ROW_GUN;
            6'd18:   data = ROW_TOWER;
            6'd19:   data = ROW_TOWER;
            6'd20:   data = ROW_TOWER;
            6'd21:   data = ROW_TOWER;
            6'd22:   data = ROW_DECK;
            6'd23:   data = ROW_DECK;
            6'd24:   data = ROW_DECK;
            6'd25:   data = ROW_DECK;
            6'd26:   data = ROW_HULL;
            6'd27:   data = ROW_HULL;
            6'd28:   data = ROW_HULL;
            6'd29:   data = ROW_HULL;
            6'd30:   data = ROW_HULL;
            6'd31:   data = ROW_HULL;
            6'd32:   data = ROW_HULL;
            6'd33:   data = ROW_HULL;
            6'd34:   data = ROW_HULL;
            6'd35:   data = ROW_HULL;
            6'd36:   data = ROW_HULL;
            6'd37:   data = ROW_HULL;
            6'd38:   data = ROW_BLANK;
            6'd39:   data = ROW_BLANK;
            // Rows past the sprite height
            default: data = ROW_BLANK;
        endcase
    end

endmodule

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`include "ship_defs.svh"

module vga_timing
    import ship_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    scan_if.source scan
);

    // Sync windows, end values are exclusive
    localparam coord_t HS_START = coord_t'(`H_VISIBLE + `H_FRONT);
    localparam coord_t HS_END   = coord_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);
    localparam coord_t VS_START = coord_t'(`V_VISIBLE + `V_FRONT);
    localparam coord_t VS_END   = coord_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);
    localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);

    coord_t x_q;
    coord_t y_q;
    coord_t x_next;
    coord_t y_next;
    logic   visible_q;
    logic   hsync_n_q;
    logic   vsync_n_q;
    logic   frame_start_q;

    always_comb begin
        x_next = x_q + coord_t'(1);
        y_next = y_q;
        if (x_q == H_LAST) begin
            x_next = '0;
            y_next = (y_q == V_LAST) ? '0 : y_q + coord_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flags are decoded from the next counter value so they line up with
    // the counters once registered
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_q           <= '0;
            y_q           <= '0;
            visible_q     <= 1'b1;
            hsync_n_q     <= 1'b1;
            vsync_n_q     <= 1'b1;
            frame_start_q <= 1'b1;
        end else begin
            x_q           <= x_next;
            y_q           <= y_next;
            visible_q     <= (x_next < coord_t'(`H_VISIBLE)) && (y_next < coord_t'(`V_VISIBLE));
            hsync_n_q     <= !((x_next >= HS_START) && (x_next < HS_END));
            vsync_n_q     <= !((y_next >= VS_START) && (y_next < VS_END));
            frame_start_q <= (x_next == '0) && (y_next == '0);
        end
    end

    assign scan.x           = x_q;
    assign scan.y           = y_q;
    assign scan.visible     = visible_q;
    assign scan.hsync_n     = hsync_n_q;
    assign scan.vsync_n     = vsync_n_q;
    assign scan.frame_start = frame_start_q;

endmodule

// ==== hw/scan_if.sv ====
`timescale 1ns/1ps

interface scan_if
    import ship_pkg::*;
();
    // Current raster position
    coord_t x;
    coord_t y;

    logic   visible;
    logic   hsync_n;
    logic   vsync_n;

    // One cycle at (0, 0)
    logic   frame_start;

    modport source (output x, y, visible, hsync_n, vsync_n, frame_start);
    modport sink   (input  x, y, visible, hsync_n, vsync_n, frame_start);

endinterface

// ==== hw/ship_pkg.sv ====
package ship_pkg;

    // Screen position or raster counter value
    typedef logic [9:0] coord_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb_t;

    // One bitmap row
    // bit 49 is the leftmost column of the sprite
    typedef logic [49:0] sprite_row_t;

    // Bitmap row index
    typedef logic [5:0] sprite_addr_t;

    // Register bank word address
    typedef logic [1:0] reg_addr_t;

    // Bus data word
    typedef logic [15:0] wb_data_t;

endpackage

// ==== hw/ship_defs.svh ====
`ifndef SHIP_DEFS_SVH
`define SHIP_DEFS_SVH

// 640x480 at 60 Hz, 25 MHz pixel clock
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_TOTAL   800

`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_TOTAL   525

// Ship bitmap size in pixels
`define SHIP_W 50
`define SHIP_H 40

// Wishbone word addresses
`define REG_SHIP_X     0
`define REG_SHIP_Y     1
`define REG_SHIP_COLOR 2
`define REG_BG_COLOR   3

`endif
